// ==== verilog/fpslice_fmt_pkg.sv ====
// Only FP32 and FP16 are supported, and vector mode means two FP16 lanes in one 32-bit slice
package fpslice_fmt_pkg;

  // --------------------------------------------------------------------------
  // Formats
  // --------------------------------------------------------------------------
  typedef enum logic [0:0] {
    fmt_fp32 = 1'b0,
    fmt_fp16 = 1'b1
  } fp_fmt_e;

  localparam int unsigned SLICE_WIDTH = 32;  // Datapath width of the slice
  localparam int unsigned NUM_LANES   = 2;   // Lane 0 is 32 bits wide, lane 1 is 16 bits wide

  localparam int unsigned FP32_WIDTH = 32;
  localparam int unsigned FP16_WIDTH = 16;

  // Register stages inside every lane
  localparam int unsigned NUM_PIPE_REGS = 2;

  // --------------------------------------------------------------------------
  // Canonical quiet NaNs
  // --------------------------------------------------------------------------
  // Positive sign, all-ones exponent, only the quiet bit set in the mantissa
  localparam logic [FP32_WIDTH-1:0] CANON_NAN_FP32 = 32'h7fc0_0000;
  localparam logic [FP16_WIDTH-1:0] CANON_NAN_FP16 = 16'h7e00;

  // --------------------------------------------------------------------------
  // Vector types
  // --------------------------------------------------------------------------
  // Full-width operand or result
  typedef logic [SLICE_WIDTH-1:0] slice_data_t;

  // One bit per lane, used for SIMD masks and lane valids
  typedef logic [NUM_LANES-1:0] lane_mask_t;

  // Request label, returned unchanged with the response
  typedef logic [3:0] tag_t;

endpackage

// ==== verilog/fpslice_op_pkg.sv ====
// Covers min/max and sign injection only, and of the status flags only NV is ever set by the slice
package fpslice_op_pkg;

  import fpslice_fmt_pkg::*;

  // --------------------------------------------------------------------------
  // Operations
  // --------------------------------------------------------------------------
  typedef enum logic [2:0] {
    op_min   = 3'd0,
    op_max   = 3'd1,
    op_sgnj  = 3'd2,  // Sign of B
    op_sgnjn = 3'd3,  // Inverted sign of B
    op_sgnjx = 3'd4   // Sign of A xor sign of B
  } noncomp_op_e;

  // IEEE 754 exception flags, same field order as the RISC-V fflags
  typedef struct packed {
    logic NV;  // Invalid operation
    logic DZ;  // Divide by zero
    logic OF;  // Overflow
    logic UF;  // Underflow
    logic NX;  // Inexact
  } status_t;

  // Travels with each item so that the packer knows how to assemble the result
  typedef struct packed {
    fp_fmt_e fmt;
    logic    vector;
  } lane_aux_t;

  // --------------------------------------------------------------------------
  // Request and response
  // --------------------------------------------------------------------------
  typedef struct packed {
    slice_data_t a;
    slice_data_t b;
    noncomp_op_e op;
    fp_fmt_e     fmt;
    logic        vector;     // Two FP16 elements, ignored for FP32
    lane_mask_t  simd_mask;  // Bit i enables the status of lane i
    tag_t        tag;
  } slice_req_t;

  typedef struct packed {
    slice_data_t result;
    status_t     status;
    tag_t        tag;
  } slice_rsp_t;

endpackage

// ==== verilog/fpslice_lane_prep.sv ====
// Purely combinational, and lane 1 only ever sees vector FP16 requests
`timescale 1ns/1ps

module fpslice_lane_prep
  import fpslice_fmt_pkg::*;
  import fpslice_op_pkg::*;
(
  input  slice_req_t             req_i,
  input  logic                   in_valid_i,
  // Lane 0 operands, full width
  output slice_data_t            lane0_a_o,
  output slice_data_t            lane0_b_o,
  // Lane 1 operands, upper FP16 element
  output logic [FP16_WIDTH-1:0]  lane1_a_o,
  output logic [FP16_WIDTH-1:0]  lane1_b_o,
  // Per-lane control
  output lane_mask_t             lane_valid_o,
  output lane_mask_t             lane_mask_o,
  output lane_aux_t              aux_o
);

  logic is_vector;  // Vector flag qualified by the format

  // A vector request only makes sense for FP16
  assign is_vector = req_i.vector & (req_i.fmt == fmt_fp16);

  // --------------------------------------------------------------------------
  // Operand slicing
  // --------------------------------------------------------------------------
  // Lane 0 gets the whole operand and works on the low bits that its format needs
  assign lane0_a_o = req_i.a;
  assign lane0_b_o = req_i.b;

  // Upper FP16 element
  assign lane1_a_o = req_i.a[SLICE_WIDTH-1 -: FP16_WIDTH];
  assign lane1_b_o = req_i.b[SLICE_WIDTH-1 -: FP16_WIDTH];

  // --------------------------------------------------------------------------
  // Lane control
  // --------------------------------------------------------------------------
  always_comb begin : lane_ctrl
    lane_valid_o[0] = in_valid_i;               // Lane 0 takes part in every request
    lane_valid_o[1] = in_valid_i & is_vector;   // Upper lane for vectors only
  end

  // The mask is applied to the lane status at the output
  assign lane_mask_o = req_i.simd_mask;

  assign aux_o = '{fmt: req_i.fmt, vector: is_vector};

endmodule

// ==== verilog/fpslice_noncomp_lane.sv ====
// FP32 is available only when lane_fp32_en is set, and an FP16 lane ignores fmt_i entirely
`timescale 1ns/1ps

module fpslice_noncomp_lane
  import fpslice_fmt_pkg::*;
  import fpslice_op_pkg::*;
#(
  parameter  bit          lane_fp32_en = 1'b1,
  localparam int unsigned lane_width   = lane_fp32_en ? FP32_WIDTH : FP16_WIDTH
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Input side
  input  logic [lane_width-1:0] a_i,
  input  logic [lane_width-1:0] b_i,
  input  noncomp_op_e           op_i,
  input  fp_fmt_e               fmt_i,
  input  tag_t                  tag_i,
  input  logic                  mask_i,
  input  lane_aux_t             aux_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic                  flush_i,
  // Output side
  output logic [lane_width-1:0] result_o,
  output status_t               status_o,
  output tag_t                  tag_o,
  output logic                  mask_o,
  output lane_aux_t             aux_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  busy_o
);

  typedef struct packed {
    logic                  sign;
    logic [FP32_WIDTH-2:0] mag;   // Exponent and mantissa, zero-extended for FP16
    logic                  nan;
    logic                  snan;
    logic                  zero;
  } operand_info_t;

  typedef struct packed {
    logic [lane_width-1:0] result;
    status_t               status;
    tag_t                  tag;
    logic                  mask;
    lane_aux_t             aux;
  } stage_t;

  logic [FP32_WIDTH-1:0] a_ext, b_ext, canon_nan, op_result;
  logic                  is_fp32, a_lt_b, inj_sign;
  operand_info_t         a_info, b_info;
  status_t               op_status;

  stage_t                 stage_in;
  stage_t                 data_q      [NUM_PIPE_REGS];
  stage_t                 data_chain  [NUM_PIPE_REGS+1];
  logic [NUM_PIPE_REGS-1:0] valid_q;
  logic [NUM_PIPE_REGS:0]   valid_chain;
  logic [NUM_PIPE_REGS:0]   ready_chain;

  function automatic operand_info_t classify(logic [FP32_WIDTH-1:0] v, logic fp32);
    operand_info_t info;
    logic          quiet;
    if (fp32) begin
      info.sign = v[31];
      info.mag  = v[30:0];
      info.nan  = (&v[30:23]) & (|v[22:0]);
      quiet     = v[22];
    end else begin
      info.sign = v[15];
      info.mag  = {16'b0, v[14:0]};
      info.nan  = (&v[14:10]) & (|v[9:0]);
      quiet     = v[9];
    end
    info.snan = info.nan & ~quiet;
    info.zero = (info.mag == '0);
    return info;
  endfunction

  // --------------------------------------------------------------------------
  // Datapath
  // --------------------------------------------------------------------------
  assign is_fp32   = lane_fp32_en && (fmt_i == fmt_fp32);
  assign a_ext     = FP32_WIDTH'(a_i);
  assign b_ext     = FP32_WIDTH'(b_i);
  assign canon_nan = is_fp32 ? CANON_NAN_FP32 : FP32_WIDTH'(CANON_NAN_FP16);

  assign a_info = classify(a_ext, is_fp32);
  assign b_info = classify(b_ext, is_fp32);

  // Sign-magnitude ordering
  always_comb begin : compare
    if (a_info.zero && b_info.zero) begin
      a_lt_b = a_info.sign & ~b_info.sign;  // -0 below +0
    end else if (a_info.sign != b_info.sign) begin
      a_lt_b = a_info.sign;
    end else if (a_info.sign) begin
      a_lt_b = a_info.mag > b_info.mag;     // Both negative, larger magnitude is smaller
    end else begin
      a_lt_b = a_info.mag < b_info.mag;
    end
  end

  always_comb begin : datapath
    op_result = a_ext;
    op_status = '0;
    inj_sign  = b_info.sign;
    case (op_i)
      op_min, op_max: begin
        if (a_info.nan && b_info.nan) begin
          op_result = canon_nan;
        end else if (a_info.nan) begin
          op_result = b_ext;
        end else if (b_info.nan) begin
          op_result = a_ext;
        end else begin
          op_result = ((op_i == op_max) ^ a_lt_b) ? a_ext : b_ext;
        end
        op_status.NV = a_info.snan | b_info.snan;
      end
      op_sgnj, op_sgnjn, op_sgnjx: begin
        if (op_i == op_sgnjn) inj_sign = ~b_info.sign;
        if (op_i == op_sgnjx) inj_sign = a_info.sign ^ b_info.sign;
        // Upper half of an FP16 result is boxed later
        op_result = is_fp32 ? {inj_sign, a_ext[30:0]} : {a_ext[31:16], inj_sign, a_ext[14:0]};
      end
      default: ;
    endcase
  end

  // --------------------------------------------------------------------------
  // Elastic pipeline
  // --------------------------------------------------------------------------
  assign stage_in = '{result: op_result[lane_width-1:0], status: op_status,
                      tag: tag_i, mask: mask_i, aux: aux_i};

  // Index 0 is the input, index i the output of register stage i-1
  always_comb begin : chain
    data_chain[0]  = stage_in;
    valid_chain[0] = in_valid_i;
    for (int i = 0; i < int'(NUM_PIPE_REGS); i++) begin
      data_chain[i+1]  = data_q[i];
      valid_chain[i+1] = valid_q[i];
    end
    ready_chain[NUM_PIPE_REGS] = out_ready_i;
    // Advance when the next stage is ready or only holds a bubble
    for (int i = int'(NUM_PIPE_REGS) - 1; i >= 0; i--) begin
      ready_chain[i] = ready_chain[i+1] | ~valid_chain[i+1];
    end
  end

  always_ff @(posedge clk_i) begin : pipe_valid
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;  // Drop everything in flight
    end else begin
      for (int i = 0; i < int'(NUM_PIPE_REGS); i++) begin
        if (ready_chain[i]) valid_q[i] <= valid_chain[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin : pipe_data
    for (int i = 0; i < int'(NUM_PIPE_REGS); i++) begin
      if (ready_chain[i] && valid_chain[i]) data_q[i] <= data_chain[i];
    end
  end

  assign in_ready_o  = ready_chain[0];
  assign out_valid_o = valid_q[NUM_PIPE_REGS-1];
  assign busy_o      = |valid_q;

  assign result_o = data_q[NUM_PIPE_REGS-1].result;
  assign status_o = data_q[NUM_PIPE_REGS-1].status;
  assign tag_o    = data_q[NUM_PIPE_REGS-1].tag;
  assign mask_o   = data_q[NUM_PIPE_REGS-1].mask;
  assign aux_o    = data_q[NUM_PIPE_REGS-1].aux;

endmodule

// ==== verilog/fpslice_result_pack.sv ====
// Combinational, and aux_i must come from lane 0 because it decides whether lane 1 counts
`timescale 1ns/1ps

module fpslice_result_pack
  import fpslice_fmt_pkg::*;
  import fpslice_op_pkg::*;
(
  input  slice_data_t                  lane0_result_i,
  input  logic [FP16_WIDTH-1:0]        lane1_result_i,
  input  lane_mask_t                   lane_valid_i,
  input  status_t [NUM_LANES-1:0]      lane_status_i,
  input  lane_mask_t                   lane_mask_i,
  input  lane_aux_t                    aux_i,
  output slice_data_t                  result_o,
  output status_t                      status_o
);

  lane_mask_t            lane_active;  // Lane holds a result that belongs to this item
  slice_data_t           lane0_boxed;
  logic [FP16_WIDTH-1:0] lane1_boxed;

  // Upper lane counts only for vector results
  assign lane_active[0] = lane_valid_i[0];
  assign lane_active[1] = lane_valid_i[1] & aux_i.vector;

  // --------------------------------------------------------------------------
  // Result packing
  // --------------------------------------------------------------------------
  // Inactive lanes read as all ones, which NaN-boxes the upper half
  assign lane0_boxed = lane_active[0] ? lane0_result_i : '1;
  assign lane1_boxed = lane_active[1] ? lane1_result_i : '1;

  always_comb begin : pack
    if (aux_i.fmt == fmt_fp32) begin
      result_o = lane0_boxed;
    end else begin
      result_o = {lane1_boxed, lane0_boxed[FP16_WIDTH-1:0]};
    end
  end

  // --------------------------------------------------------------------------
  // Status collapse
  // --------------------------------------------------------------------------
  always_comb begin : collapse
    status_o = '0;
    for (int i = 0; i < int'(NUM_LANES); i++) begin
      if (lane_active[i] && lane_mask_i[i]) begin
        status_o = status_o | lane_status_i[i];  // Masked lanes keep their result, lose flags
      end
    end
  end

endmodule

// ==== verilog/fpslice_top.sv ====
// Valid/ready on both sides, with responses returned in order two cycles after acceptance
`timescale 1ns/1ps

module fpslice_top
  import fpslice_fmt_pkg::*;
  import fpslice_op_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Request side
  input  slice_req_t req_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  logic       flush_i,
  // Response side
  output slice_rsp_t rsp_o,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output logic       busy_o
);

  slice_data_t             lane0_a, lane0_b, lane0_result, packed_result;
  logic [FP16_WIDTH-1:0]   lane1_a, lane1_b, lane1_result;
  lane_mask_t              lane_valid, lane_mask_in, lane_mask_out;
  lane_mask_t              lane_out_valid, lane_busy;
  lane_aux_t               aux_in, lane0_aux;
  status_t [NUM_LANES-1:0] lane_status;
  status_t                 packed_status;
  tag_t                    lane0_tag;
  logic                    lane0_ready, lane1_in_valid, lane1_out_ready;

  fpslice_lane_prep i_prep (
    .req_i        ( req_i        ),
    .in_valid_i   ( in_valid_i   ),
    .lane0_a_o    ( lane0_a      ),
    .lane0_b_o    ( lane0_b      ),
    .lane1_a_o    ( lane1_a      ),
    .lane1_b_o    ( lane1_b      ),
    .lane_valid_o ( lane_valid   ),
    .lane_mask_o  ( lane_mask_in ),
    .aux_o        ( aux_in       )
  );

  // --------------------------------------------------------------------------
  // Lanes
  // --------------------------------------------------------------------------
  // Lane 1 must not take a vector item that lane 0 refuses
  assign lane1_in_valid  = lane_valid[1] & lane0_ready;
  assign lane1_out_ready = out_ready_i & lane0_aux.vector;  // Pops only with a vector head

  fpslice_noncomp_lane #(.lane_fp32_en(1'b1)) i_lane0 (
    .clk_i, .rst_n_i, .flush_i,
    .a_i         ( lane0_a           ),
    .b_i         ( lane0_b           ),
    .op_i        ( req_i.op          ),
    .fmt_i       ( req_i.fmt         ),
    .tag_i       ( req_i.tag         ),
    .mask_i      ( lane_mask_in[0]   ),
    .aux_i       ( aux_in            ),
    .in_valid_i  ( lane_valid[0]     ),
    .in_ready_o  ( lane0_ready       ),
    .result_o    ( lane0_result      ),
    .status_o    ( lane_status[0]    ),
    .tag_o       ( lane0_tag         ),
    .mask_o      ( lane_mask_out[0]  ),
    .aux_o       ( lane0_aux         ),
    .out_valid_o ( lane_out_valid[0] ),
    .out_ready_i ( out_ready_i       ),
    .busy_o      ( lane_busy[0]      )
  );

  fpslice_noncomp_lane #(.lane_fp32_en(1'b0)) i_lane1 (
    .clk_i, .rst_n_i, .flush_i,
    .a_i         ( lane1_a           ),
    .b_i         ( lane1_b           ),
    .op_i        ( req_i.op          ),
    .fmt_i       ( req_i.fmt         ),
    .tag_i       ( '0                ),  // Tag comes from lane 0
    .mask_i      ( lane_mask_in[1]   ),
    .aux_i       ( aux_in            ),
    .in_valid_i  ( lane1_in_valid    ),
    .in_ready_o  (                   ),
    .result_o    ( lane1_result      ),
    .status_o    ( lane_status[1]    ),
    .tag_o       (                   ),
    .mask_o      ( lane_mask_out[1]  ),
    .aux_o       (                   ),
    .out_valid_o ( lane_out_valid[1] ),
    .out_ready_i ( lane1_out_ready   ),
    .busy_o      ( lane_busy[1]      )
  );

  fpslice_result_pack i_pack (
    .lane0_result_i ( lane0_result   ),
    .lane1_result_i ( lane1_result   ),
    .lane_valid_i   ( lane_out_valid ),
    .lane_status_i  ( lane_status    ),
    .lane_mask_i    ( lane_mask_out  ),
    .aux_i          ( lane0_aux      ),
    .result_o       ( packed_result  ),
    .status_o       ( packed_status  )
  );

  // Lane 0 owns the outside handshake
  assign in_ready_o  = lane0_ready;
  assign out_valid_o = lane_out_valid[0];
  assign busy_o      = |lane_busy;
  assign rsp_o       = '{result: packed_result, status: packed_status, tag: lane0_tag};

endmodule

// ==== testbench/fpslice_checker.sv ====
// Every request must be announced through expect_response before it is driven, in request order
`timescale 1ns/1ps

module fpslice_checker
  import fpslice_fmt_pkg::*;
  import fpslice_op_pkg::*;
(
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       in_valid_i,
  input logic       in_ready_i,
  input logic       flush_i,
  input slice_rsp_t rsp_i,
  input logic       out_valid_i,
  input logic       out_ready_i,
  input logic       busy_i
);

  slice_rsp_t  upcoming[$];     // Announced, not yet accepted
  slice_rsp_t  outstanding[$];  // Accepted, response not yet taken
  slice_rsp_t  stalled_rsp;
  logic        stalled        = 1'b0;
  int unsigned checked_count  = 0;
  int unsigned dropped_count  = 0;
  int unsigned mismatch_count = 0;
  int unsigned protocol_count = 0;

  task automatic expect_response(input slice_rsp_t rsp_v);
    upcoming.push_back(rsp_v);
  endtask

  function automatic int unsigned pending_count();
    return upcoming.size() + outstanding.size();
  endfunction

  function automatic int unsigned error_count();
    return mismatch_count + protocol_count;
  endfunction

  task automatic print_counts();
    $display("Checked %0d, dropped by flush %0d, mismatches %0d, protocol errors %0d, missing %0d",
             checked_count, dropped_count, mismatch_count, protocol_count, pending_count());
  endtask

  task automatic compare_response(input slice_rsp_t expected, input slice_rsp_t actual);
    if (actual.result !== expected.result) begin
      $display("[FAIL] %0d ns: tag %h result %h, expected %h", $time, expected.tag,
               actual.result, expected.result);
      mismatch_count++;
    end
    if (actual.status !== expected.status) begin
      $display("[FAIL] %0d ns: tag %h status %b, expected %b", $time, expected.tag,
               actual.status, expected.status);
      mismatch_count++;
    end
    if (actual.tag !== expected.tag) begin
      $display("[FAIL] %0d ns: tag %h, expected %h", $time, actual.tag, expected.tag);
      mismatch_count++;
    end
    checked_count++;
  endtask

  // --------------------------------------------------------------------------
  // Handshakes, sampled on the rising edge
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin : watch_handshakes
    slice_rsp_t expected;
    if (rst_n_i === 1'b1) begin
      if (busy_i !== (outstanding.size() != 0)) begin
        $display("[FAIL] %0d ns: busy_o is %b with %0d items outstanding", $time, busy_i,
                 outstanding.size());
        protocol_count++;
      end
      // Room for a request unless both stages are full and the head is not taken
      if (in_ready_i !== (outstanding.size() < NUM_PIPE_REGS || out_ready_i === 1'b1)) begin
        $display("[FAIL] %0d ns: in_ready_o is %b with %0d items outstanding, out_ready_i %b",
                 $time, in_ready_i, outstanding.size(), out_ready_i);
        protocol_count++;
      end
      // A stalled response must not change or vanish
      if (stalled && (out_valid_i !== 1'b1 || rsp_i !== stalled_rsp)) begin
        $display("[FAIL] %0d ns: response changed before it was taken", $time);
        protocol_count++;
      end
      stalled = 1'b0;
      if (flush_i === 1'b1) begin
        dropped_count += outstanding.size();
        outstanding.delete();
      end else begin
        if (out_valid_i === 1'b1 && out_ready_i === 1'b1) begin
          if (outstanding.size() == 0) begin
            $display("Error at %0d ns: a response came out with no request in flight", $time);
            protocol_count++;
          end else begin
            expected = outstanding.pop_front();
            compare_response(expected, rsp_i);
          end
        end else if (out_valid_i === 1'b1) begin
          stalled     = 1'b1;
          stalled_rsp = rsp_i;
        end
        if (in_valid_i === 1'b1 && in_ready_i === 1'b1) begin
          if (upcoming.size() == 0) begin
            $display("Error at %0d ns: a request was accepted that was never announced", $time);
            protocol_count++;
          end else begin
            outstanding.push_back(upcoming.pop_front());
          end
        end
      end
    end
  end

  always @(negedge clk_i) begin : watch_reset
    if (rst_n_i === 1'b0 &&
        (out_valid_i !== 1'b0 || busy_i !== 1'b0 || in_ready_i !== 1'b1)) begin
      $display("[FAIL] %0d ns: in reset out_valid_o %b busy_o %b in_ready_o %b", $time,
               out_valid_i, busy_i, in_ready_i);
      protocol_count++;
    end
  end

endmodule

// ==== testbench/fpslice_tb.sv ====
// Reads testbench/fpslice_tests.txt relative to the project root, so start the simulator there
`timescale 1ns/1ps

module fpslice_tb
  import fpslice_fmt_pkg::*;
  import fpslice_op_pkg::*;
();

  typedef enum logic [1:0] {
    step_test,
    step_hold,   // Keep out_ready low from here on
    step_flush   // Flush, then release out_ready
  } step_kind_e;

  typedef struct packed {
    step_kind_e kind;
    slice_req_t req;
    slice_rsp_t rsp;
  } step_t;

  logic        clk;
  logic        rst_n;
  slice_req_t  req;
  logic        in_valid;
  logic        in_ready;
  logic        flush;
  slice_rsp_t  rsp;
  logic        out_valid;
  logic        out_ready;
  logic        busy;

  step_t       steps[$];
  int unsigned test_count;
  int unsigned load_errors;
  logic        loaded;
  logic        hold_rsp;  // Items stay in flight while set

  fpslice_top i_dut (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .req_i       ( req       ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .flush_i     ( flush     ),
    .rsp_o       ( rsp       ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .busy_o      ( busy      )
  );

  fpslice_checker i_checker (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .in_valid_i  ( in_valid  ),
    .in_ready_i  ( in_ready  ),
    .flush_i     ( flush     ),
    .rsp_i       ( rsp       ),
    .out_valid_i ( out_valid ),
    .out_ready_i ( out_ready ),
    .busy_i      ( busy      )
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Test file
  // --------------------------------------------------------------------------
  task automatic load_tests();
    int               fd;
    int               n;
    logic [8*160-1:0] line;
    logic [8*4-1:0]   kind;
    logic [31:0]      op_v, fmt_v, vec_v, mask_v, a_v, b_v, tag_v, res_v, nv_v;
    step_t            step;
    fd = $fopen("testbench/fpslice_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the tests file testbench/fpslice_tests.txt");
      load_errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", kind, op_v, fmt_v, vec_v, mask_v,
                  a_v, b_v, tag_v, res_v, nv_v);
      step = '0;
      if (n < 1 || kind == "#") continue;
      if (kind == "H") begin
        step.kind = step_hold;
        steps.push_back(step);
      end else if (kind == "F") begin
        step.kind = step_flush;
        steps.push_back(step);
      end else if (kind == "T" && n == 10) begin
        step.kind          = step_test;
        step.req.a         = a_v;
        step.req.b         = b_v;
        step.req.op        = noncomp_op_e'(op_v[2:0]);
        step.req.fmt       = fp_fmt_e'(fmt_v[0]);
        step.req.vector    = vec_v[0];
        step.req.simd_mask = mask_v[1:0];
        step.req.tag       = tag_v[3:0];
        step.rsp.result    = res_v;
        step.rsp.status.NV = nv_v[0];  // Other flags never set
        step.rsp.tag       = tag_v[3:0];
        steps.push_back(step);
        test_count++;
      end else begin
        $display("Malformed line in the tests file: %0s", line);
        load_errors++;
      end
    end
    $fclose(fd);
  endtask

  // --------------------------------------------------------------------------
  // Stimulus, all driven on falling edges
  // --------------------------------------------------------------------------
  task automatic send_request(input slice_req_t req_v, input slice_rsp_t rsp_v);
    int unsigned gap;
    gap = $urandom % 3;
    repeat (gap) @(negedge clk);
    i_checker.expect_response(rsp_v);
    req      = req_v;
    in_valid = 1'b1;
    do begin
      @(posedge clk);
    end while (in_ready !== 1'b1);
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic hold_responses();
    while (i_checker.pending_count() != 0) begin
      @(negedge clk);
    end
    hold_rsp = 1'b1;
    @(negedge clk);
  endtask

  task automatic flush_pipeline();
    flush = 1'b1;
    @(negedge clk);
    flush    = 1'b0;
    hold_rsp = 1'b0;
  endtask

  initial begin : ready_gen
    out_ready = 1'b0;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      out_ready = hold_rsp ? 1'b0 : (($urandom % 4) != 0);  // Stall about one cycle in four
    end
  end

  initial begin : main
    rst_n       = 1'b0;
    req         = '0;
    in_valid    = 1'b0;
    flush       = 1'b0;
    hold_rsp    = 1'b0;
    loaded      = 1'b0;
    test_count  = 0;
    load_errors = 0;
    void'($urandom(32'h8a0edbce));
    load_tests();
    loaded = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    foreach (steps[i]) begin
      case (steps[i].kind)
        step_test:  send_request(steps[i].req, steps[i].rsp);
        step_hold:  hold_responses();
        step_flush: flush_pipeline();
        default: ;
      endcase
    end
    while (i_checker.pending_count() != 0) begin
      @(negedge clk);
    end
    repeat (5) @(negedge clk);  // Idle tail, busy_o must stay low
    i_checker.print_counts();
    if (i_checker.error_count() == 0 && load_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (loaded === 1'b1);
    repeat (test_count * 40 + 200) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles, %0d responses still missing",
             test_count * 40 + 200, i_checker.pending_count());
    i_checker.print_counts();
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== testbench/fpslice_tests.txt ====
# kind op fmt vec mask a b tag result nv, kind T test H hold responses F flush, all hex
# op 0 min 1 max 2 sgnj 3 sgnjn 4 sgnjx, fmt 0 fp32 1 fp16
T 0 0 0 1 3f800000 40000000 0 3f800000 0
T 1 0 0 1 3f800000 40000000 1 40000000 0
T 0 0 0 1 bf800000 40000000 2 bf800000 0
T 1 0 0 1 c0400000 c0000000 3 c0000000 0
T 0 0 0 1 80000000 00000000 4 80000000 0
T 1 0 0 1 80000000 00000000 5 00000000 0
T 0 0 0 1 7fc00000 40000000 6 40000000 0
T 1 0 0 1 7f800001 3f800000 7 3f800000 1
T 0 0 0 1 7fc00000 7fa00000 8 7fc00000 1
T 2 0 0 1 3f800000 c0000000 9 bf800000 0
T 3 0 0 1 3f800000 c0000000 a 3f800000 0
T 4 0 0 1 bf800000 c0000000 b 3f800000 0
T 2 0 0 1 7f800001 80000000 c ff800001 0
T 1 0 0 0 7f800001 3f800000 d 3f800000 0
T 1 0 1 3 40000000 3f800000 e 40000000 0
H
T 1 0 0 1 3f800000 40000000 f 40000000 0
T 0 1 1 3 40003c00 3c004000 0 3c003c00 0
F
T 0 1 0 1 12343c00 abcd4000 1 ffff3c00 0
T 1 1 0 1 0000bc00 0000c000 2 ffffbc00 0
T 1 1 0 1 00007e00 0000c000 3 ffffc000 0
T 0 1 0 1 00007c01 00003c00 4 ffff3c00 1
T 1 1 0 1 00007e00 00007c01 5 ffff7e00 1
T 3 1 0 1 00003c00 00003c00 6 ffffbc00 0
T 4 1 0 1 0000bc00 0000c000 7 ffff3c00 0
T 0 1 0 1 00008000 00000000 8 ffff8000 0
T 1 1 0 1 00007c00 0000fc00 9 ffff7c00 0
T 0 1 1 3 40003c00 3c004000 a 3c003c00 0
T 1 1 1 3 c0007e00 bc00bc00 b bc00bc00 0
T 2 1 1 3 3c004000 80000000 c bc004000 0
T 4 1 1 3 bc00bc00 80000000 d 3c00bc00 0
T 0 1 1 1 7c013c00 40004000 e 40003c00 0
T 0 1 1 2 7c013c00 40004000 f 40003c00 1
T 1 1 1 2 40007c01 3c003c00 0 40003c00 0
T 0 1 1 3 7e008000 7c010000 1 7e008000 1

// ==== compile.f ====
verilog/fpslice_fmt_pkg.sv
verilog/fpslice_op_pkg.sv
verilog/fpslice_lane_prep.sv
verilog/fpslice_noncomp_lane.sv
verilog/fpslice_result_pack.sv
verilog/fpslice_top.sv
testbench/fpslice_checker.sv
testbench/fpslice_tb.sv
